//--- sim.f
common/isa_pkg.sv
common/uop_pkg.sv
decode/imm_gen.sv
decode/op_select.sv
decode/wctl_decode.sv
decode/instr_decoder.sv
source/elastic_buffer.sv
decode/decode_stage.sv
dv/decode_stage_chk.sv
dv/decode_stage_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module decode_stage_tb -o Vdecode_stage_tb
	out=$$(./obj_dir/Vdecode_stage_tb); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- dv/decode_stage_tb.sv
`default_nettype none
`timescale 1ns/10ps

module decode_stage_tb;
    import isa_pkg::*;
    import uop_pkg::*;

    localparam int NUM_VEC = 24;

    typedef struct packed {
        instr_t     instr;
        xlen_t      pc;
        wid_t       wid;
        ex_t        ex;
        op_t        op;
        xtype_t     xt;
        logic [3:0] flags; // use_pc, use_imm, csr_imm, is_neg
        xlen_t      imm;
        logic       wb;
        logic [2:0] used;
        logic       unlock;
    } vec_t;

    logic     clk;
    logic     rst;
    logic     fetch_valid;
    fetch_t   fetch_data;
    logic     fetch_ready;
    logic     decode_valid;
    uop_t     decode_data;
    logic     decode_ready;
    sched_t   sched;

    vec_t        table_v [NUM_VEC];
    uop_t        exp_q [$];
    logic [31:0] lfsr = 32'hbef6;
    int          errors = 0;
    int          n_accept = 0;
    int          n_strobe = 0;
    int          n_out = 0;

    decode_stage i_decode_stage (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .fetch_ready  (fetch_ready),
        .decode_valid (decode_valid),
        .decode_data  (decode_data),
        .decode_ready (decode_ready),
        .sched        (sched)
    );

    bind decode_stage decode_stage_chk i_chk (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode_data  (decode_data),
        .sched        (sched)
    );

    always #10 clk = !clk;

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return b;
    endfunction

    function automatic vec_t mk(instr_t i, ex_t ex, op_t op, xtype_t xt, logic [3:0] fl,
                                xlen_t imm, logic wb, logic [2:0] used, logic unl);
        vec_t v;
        v = '{i, 32'h0, 2'd0, ex, op, xt, fl, imm, wb, used, unl};
        return v;
    endfunction

    // Register fields come straight from the RV32 layout
    function automatic uop_t expect_uop(vec_t v, int idx);
        uop_t u;
        u = '0;
        u.uuid                 = uuid_t'(idx);
        u.wid                  = v.wid;
        u.tmask                = ~tmask_t'(idx);
        u.pc                   = v.pc;
        u.ex_type              = v.ex;
        u.op_type              = v.op;
        u.op_args.xtype        = v.xt;
        u.op_args.use_pc       = v.flags[3];
        u.op_args.use_imm      = v.flags[2];
        u.op_args.csr_imm      = v.flags[1];
        u.op_args.is_neg       = v.flags[0];
        u.op_args.imm.word     = v.imm;
        u.wb                   = v.wb;
        u.used_rs              = v.used;
        u.rd                   = v.instr[11:7];
        u.rs1                  = v.instr[19:15];
        u.rs2                  = v.instr[24:20];
        u.rs3                  = v.instr[31:27];
        return u;
    endfunction

    task automatic load_table();
        table_v[0]  = mk(32'hFFB10093, EX_ALU, 4'h0, XT_ARITH, 4'b0100, 32'hFFFFFFFB, 1, 3'b001, 1);
        table_v[1]  = mk(32'h40725193, EX_ALU, 4'h9, XT_ARITH, 4'b0100, 32'h7, 1, 3'b001, 1);
        table_v[2]  = mk(32'h407302B3, EX_ALU, 4'h8, XT_ARITH, 4'b0000, 32'h0, 1, 3'b011, 1);
        table_v[3]  = mk(32'h00208033, EX_ALU, 4'h0, XT_ARITH, 4'b0000, 32'h0, 0, 3'b011, 1);
        table_v[4]  = mk(32'h123450B7, EX_ALU, 4'hA, XT_ARITH, 4'b0100, 32'h12345000, 1, 3'b000, 1);
        table_v[5]  = mk(32'h00001117, EX_ALU, 4'hB, XT_ARITH, 4'b1100, 32'h1000, 1, 3'b000, 1);
        table_v[6]  = mk(32'h008000EF, EX_ALU, 4'h6, XT_BRANCH, 4'b1100, 32'h8, 1, 3'b000, 0);
        table_v[7]  = mk(32'h00C08067, EX_ALU, 4'h7, XT_BRANCH, 4'b0100, 32'hC, 0, 3'b001, 0);
        table_v[8]  = mk(32'hFE209EE3, EX_ALU, 4'h1, XT_BRANCH, 4'b1100, 32'hFFFFFFFC, 0, 3'b011, 0);
        table_v[9]  = mk(32'h00000073, EX_ALU, 4'h8, XT_BRANCH, 4'b1100, 32'h4, 0, 3'b000, 0);
        table_v[10] = mk(32'h30200073, EX_ALU, 4'hC, XT_BRANCH, 4'b1100, 32'h4, 0, 3'b000, 0);
        table_v[11] = mk(32'h00832283, EX_LSU, 4'h2, XT_ARITH, 4'b0000, 32'h8, 1, 3'b001, 1);
        table_v[12] = mk(32'hFE742E23, EX_LSU, 4'hA, XT_ARITH, 4'b0000, 32'hFFC, 0, 3'b011, 1);
        table_v[13] = mk(32'h0000000F, EX_LSU, 4'hF, XT_ARITH, 4'b0000, 32'h0, 0, 3'b000, 1);
        table_v[14] = mk(32'h023100B3, EX_ALU, 4'h0, XT_MULDIV, 4'b0000, 32'h0, 1, 3'b011, 1);
        table_v[15] = mk(32'h0262D233, EX_ALU, 4'h5, XT_MULDIV, 4'b0000, 32'h0, 1, 3'b011, 1);
        // CSR payload is {addr, zimm}
        table_v[16] = mk(32'h001120F3, EX_SFU, 4'h8, XT_ARITH, 4'b0000, 32'h22, 1, 3'b001, 0);
        table_v[17] = mk(32'hB002D1F3, EX_SFU, 4'h7, XT_ARITH, 4'b0010, 32'h16005, 1, 3'b000, 1);
        table_v[18] = mk(32'h0000800B, EX_SFU, 4'h0, XT_ARITH, 4'b0000, 32'h0, 0, 3'b001, 0);
        table_v[19] = mk(32'h0011A10B, EX_SFU, 4'h2, XT_ARITH, 4'b0001, 32'h0, 1, 3'b001, 0);
        table_v[20] = mk(32'h0052508B, EX_SFU, 4'h5, XT_ARITH, 4'b0001, 32'h0, 0, 3'b011, 0);
        table_v[21] = mk(32'h0020C00B, EX_SFU, 4'h4, XT_ARITH, 4'b0000, 32'h0, 0, 3'b011, 0);
        table_v[22] = mk(32'h0201118B, EX_ALU, 4'h1, XT_OTHER, 4'b0000, 32'h0, 1, 3'b001, 1);
        table_v[23] = mk(32'h0261418B, EX_ALU, 4'h4, XT_OTHER, 4'b0000, 32'h0, 1, 3'b011, 1);
        for (int i = 0; i < NUM_VEC; i++) begin
            table_v[i].pc  = 32'h8000_0000 + 32'(i * 4);
            table_v[i].wid = wid_t'(i);
        end
    endtask

    // Offer one entry and hold it until the stage takes it
    task automatic offer(int idx);
        logic acc;
        fetch_valid      = 1'b1;
        fetch_data.uuid  = uuid_t'(idx);
        fetch_data.wid   = table_v[idx].wid;
        fetch_data.tmask = ~tmask_t'(idx);
        fetch_data.pc    = table_v[idx].pc;
        fetch_data.instr = table_v[idx].instr;
        forever begin
            @(negedge clk);
            acc = fetch_ready;
            if (sched.valid) begin
                n_strobe++;
            end
            if (acc) begin
                n_accept++;
                exp_q.push_back(expect_uop(table_v[idx], idx));
                assert (sched.unlock == table_v[idx].unlock && sched.wid == table_v[idx].wid)
                    else begin
                        errors++;
                        $display("Mismatch at %0t: entry %0d sched unlock %b wid %0d",
                                 $time, idx, sched.unlock, sched.wid);
                    end
            end
            @(posedge clk);
            #1;
            if (acc) begin
                break;
            end
        end
        fetch_valid = 1'b0;
    endtask

    // Back-pressure, ready low about one cycle in four
    always @(posedge clk) begin
        #1;
        decode_ready = take_bit() | take_bit();
    end

    always @(negedge clk) begin
        uop_t exp_u;
        if (!rst && decode_valid && decode_ready) begin
            n_out++;
            assert (exp_q.size() != 0)
                else begin
                    errors++;
                    $display("Output handshake at %0t with no instruction outstanding", $time);
                end
            if (exp_q.size() != 0) begin
                exp_u = exp_q.pop_front();
                assert (decode_data == exp_u)
                    else begin
                        errors++;
                        $display("Mismatch at %0t: uuid %0d got %h expected %h",
                                 $time, exp_u.uuid, decode_data, exp_u);
                    end
            end
        end
    end

    initial begin
        #(200 * NUM_VEC + 2000);
        $display("Timeout, the run did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        fetch_data   = '0;
        decode_ready = 1'b0;
        load_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_VEC; i++) begin
            offer(i);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        assert (n_accept == NUM_VEC && n_out == NUM_VEC && n_strobe == NUM_VEC)
            else begin
                errors++;
                $display("Mismatch at %0t: accepted %0d, output %0d, strobes %0d",
                         $time, n_accept, n_out, n_strobe);
            end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/decode_stage_chk.sv
`default_nettype none
`timescale 1ns/10ps

module decode_stage_chk (
    input logic            clk,
    input logic            rst,
    input logic            fetch_valid,
    input logic            fetch_ready,
    input logic            decode_valid,
    input logic            decode_ready,
    input uop_pkg::uop_t   decode_data,
    input uop_pkg::sched_t sched
);

    a_reset_idle: assert property (@(posedge clk) rst |=> !decode_valid)
        else $error("decode_valid high right after reset");

    // Held output must not move until taken
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        decode_valid && !decode_ready |=> decode_valid && $stable(decode_data))
        else $error("decode_data changed while stalled");

    a_sched_strobe: assert property (@(posedge clk) disable iff (rst)
        sched.valid == (fetch_valid && fetch_ready))
        else $error("sched.valid differs from the fetch handshake");

endmodule

`default_nettype wire

//--- decode/decode_stage.sv
`default_nettype none
`timescale 1ns/10ps

module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_valid,
    input  uop_pkg::fetch_t  fetch_data,
    output logic             fetch_ready,
    output logic             decode_valid,
    output uop_pkg::uop_t    decode_data,
    input  logic             decode_ready,
    output uop_pkg::sched_t  sched
);
    import uop_pkg::*;

    xlen_t      i_imm;
    xlen_t      s_imm;
    xlen_t      b_imm;
    xlen_t      u_imm;
    xlen_t      j_imm;
    op_t        alu_op;
    op_t        br_op;
    op_t        sys_op;
    op_t        md_op;
    op_t        csr_op;
    op_t        wctl_op;
    logic       wctl_neg;
    logic [2:0] wctl_use;
    uop_t       uop;

    imm_gen i_imm_gen (
        .instr (fetch_data.instr),
        .i_imm (i_imm),
        .s_imm (s_imm),
        .b_imm (b_imm),
        .u_imm (u_imm),
        .j_imm (j_imm)
    );

    op_select i_op_select (
        .instr  (fetch_data.instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op),
        .md_op  (md_op),
        .csr_op (csr_op)
    );

    wctl_decode i_wctl_decode (
        .instr    (fetch_data.instr),
        .wctl_op  (wctl_op),
        .is_neg   (wctl_neg),
        .use_mask (wctl_use)
    );

    instr_decoder i_instr_decoder (
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .i_imm       (i_imm),
        .s_imm       (s_imm),
        .b_imm       (b_imm),
        .u_imm       (u_imm),
        .j_imm       (j_imm),
        .alu_op      (alu_op),
        .br_op       (br_op),
        .sys_op      (sys_op),
        .md_op       (md_op),
        .csr_op      (csr_op),
        .wctl_op     (wctl_op),
        .wctl_neg    (wctl_neg),
        .wctl_use    (wctl_use),
        .uop         (uop),
        .sched       (sched)
    );

    elastic_buffer i_out_buf (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fetch_valid),
        .in_data   (uop),
        .in_ready  (fetch_ready),
        .out_valid (decode_valid),
        .out_data  (decode_data),
        .out_ready (decode_ready)
    );

endmodule

`default_nettype wire

//--- source/elastic_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module elastic_buffer (
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  uop_pkg::uop_t in_data,
    output logic          in_ready,
    output logic          out_valid,
    output uop_pkg::uop_t out_data,
    input  logic          out_ready
);
    import uop_pkg::*;

    uop_t       mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Push and pop in one cycle leave the count unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

endmodule

`default_nettype wire

//--- decode/instr_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module instr_decoder (
    input  uop_pkg::fetch_t fetch_data,
    input  logic            fetch_valid,
    input  logic            fetch_ready,
    input  uop_pkg::xlen_t  i_imm,
    input  uop_pkg::xlen_t  s_imm,
    input  uop_pkg::xlen_t  b_imm,
    input  uop_pkg::xlen_t  u_imm,
    input  uop_pkg::xlen_t  j_imm,
    input  uop_pkg::op_t    alu_op,
    input  uop_pkg::op_t    br_op,
    input  uop_pkg::op_t    sys_op,
    input  uop_pkg::op_t    md_op,
    input  uop_pkg::op_t    csr_op,
    input  uop_pkg::op_t    wctl_op,
    input  logic            wctl_neg,
    input  logic [2:0]      wctl_use,
    output uop_pkg::uop_t   uop,
    output uop_pkg::sched_t sched
);
    import isa_pkg::*;
    import uop_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    csr_addr_t csr_addr;
    reg_idx_t  rd;
    reg_idx_t  rs1;
    ex_t       ex_type;
    op_t       op_type;
    op_args_t  op_args;
    logic      use_rd;
    logic      use_rs1;
    logic      use_rs2;
    logic      is_wstall;

    assign opcode   = fetch_data.instr[6:0];
    assign funct3   = fetch_data.instr[14:12];
    assign funct7   = fetch_data.instr[31:25];
    assign csr_addr = fetch_data.instr[31:20];
    assign rd       = fetch_data.instr[11:7];
    assign rs1      = fetch_data.instr[19:15];

    always_comb begin
        ex_type   = EX_ALU;
        op_type   = OP_ADD;
        op_args   = '0;
        use_rd    = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_wstall = 1'b0;
        case (opcode)
            OPC_IMM: begin
                op_type          = alu_op;
                op_args.use_imm  = 1'b1;
                op_args.imm.word = i_imm;
                use_rd           = 1'b1;
                use_rs1          = 1'b1;
            end
            OPC_REG: begin
                op_type       = (funct7 == F7_MULDIV) ? md_op : alu_op;
                op_args.xtype = (funct7 == F7_MULDIV) ? XT_MULDIV : XT_ARITH;
                use_rd        = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                op_type          = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
                op_args.use_pc   = (opcode == OPC_AUIPC);
                op_args.use_imm  = 1'b1;
                op_args.imm.word = u_imm;
                use_rd           = 1'b1;
            end
            OPC_JAL, OPC_JALR, OPC_BRANCH: begin
                op_args.xtype   = XT_BRANCH;
                op_args.use_imm = 1'b1;
                is_wstall       = 1'b1; // next PC unknown until resolved
                if (opcode == OPC_JAL) begin
                    op_type          = OP_JAL;
                    op_args.use_pc   = 1'b1;
                    op_args.imm.word = j_imm;
                    use_rd           = 1'b1;
                end else if (opcode == OPC_JALR) begin
                    op_type          = OP_JALR;
                    op_args.imm.word = i_imm;
                    use_rd           = 1'b1;
                    use_rs1          = 1'b1;
                end else begin
                    op_type          = br_op;
                    op_args.use_pc   = 1'b1;
                    op_args.imm.word = b_imm;
                    use_rs1          = 1'b1;
                    use_rs2          = 1'b1;
                end
            end
            OPC_LOAD: begin
                ex_type                = EX_LSU;
                op_type                = OP_LD | {1'b0, funct3};
                op_args.imm.lsu.offset = i_imm[11:0];
                use_rd                 = 1'b1;
                use_rs1                = 1'b1;
            end
            OPC_STORE: begin
                ex_type                = EX_LSU;
                op_type                = OP_ST | {1'b0, funct3};
                op_args.imm.lsu.offset = s_imm[11:0];
                use_rs1                = 1'b1;
                use_rs2                = 1'b1;
            end
            OPC_FENCE: begin
                ex_type = EX_LSU;
                op_type = OP_FENCE;
            end
            OPC_SYS: begin
                use_rd = 1'b1;
                if (funct3[1:0] != 2'b00) begin
                    ex_type              = EX_SFU;
                    op_type              = csr_op;
                    op_args.csr_imm      = funct3[2];
                    op_args.imm.csr.addr = csr_addr;
                    op_args.imm.csr.zimm = rs1;
                    use_rs1              = !funct3[2];
                    is_wstall            = (csr_addr <= CSR_FPU_LAST);
                end else begin
                    op_type          = sys_op;
                    op_args.xtype    = XT_BRANCH;
                    op_args.use_pc   = 1'b1;
                    op_args.use_imm  = 1'b1;
                    op_args.imm.word = 32'd4; // return address PC+4
                    is_wstall        = 1'b1;
                end
            end
            OPC_EXT1: begin
                if (funct7 == F7_WCTL) begin
                    ex_type        = EX_SFU;
                    op_type        = wctl_op;
                    op_args.is_neg = wctl_neg;
                    use_rd         = wctl_use[0];
                    use_rs1        = wctl_use[1];
                    use_rs2        = wctl_use[2];
                    is_wstall      = 1'b1;
                end else if (funct7 == F7_VOTE) begin
                    op_type       = {1'b0, funct3};
                    op_args.xtype = XT_OTHER;
                    use_rd        = 1'b1;
                    use_rs1       = 1'b1;
                    use_rs2       = funct3[2]; // SHFL only
                end
            end
            default: ;
        endcase
    end

    assign uop = '{
        uuid:    fetch_data.uuid,
        wid:     fetch_data.wid,
        tmask:   fetch_data.tmask,
        pc:      fetch_data.pc,
        ex_type: ex_type,
        op_type: op_type,
        op_args: op_args,
        wb:      use_rd && (rd != '0), // x0 is never written
        used_rs: {1'b0, use_rs2, use_rs1},
        rd:      rd,
        rs1:     rs1,
        rs2:     fetch_data.instr[24:20],
        rs3:     fetch_data.instr[31:27]
    };

    assign sched.valid  = fetch_valid && fetch_ready;
    assign sched.wid    = fetch_data.wid;
    assign sched.unlock = !is_wstall;

endmodule

`default_nettype wire

//--- decode/wctl_decode.sv
`default_nettype none
`timescale 1ns/10ps

module wctl_decode (
    input  isa_pkg::instr_t instr,
    output uop_pkg::op_t    wctl_op,
    output logic            is_neg,
    output logic [2:0]      use_mask // {rs2, rs1, rd}
);
    import isa_pkg::*;
    import uop_pkg::*;

    funct3_t  funct3;
    reg_idx_t rd;
    reg_idx_t rs2;

    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs2    = instr[24:20];

    always_comb begin
        is_neg = 1'b0;
        case (funct3)
            3'd0: begin
                wctl_op  = OP_TMC;
                use_mask = 3'b010;
            end
            3'd1: begin
                wctl_op  = OP_WSPAWN;
                use_mask = 3'b110;
            end
            3'd2: begin
                wctl_op  = OP_SPLIT;
                is_neg   = rs2[0];
                use_mask = 3'b011; // rd returns the split state
            end
            3'd3: begin
                wctl_op  = OP_JOIN;
                use_mask = 3'b010;
            end
            3'd4: begin
                wctl_op  = OP_BAR;
                use_mask = 3'b110;
            end
            3'd5: begin
                wctl_op  = OP_PRED;
                is_neg   = rd[0]; // rd field only carries the flag
                use_mask = 3'b110;
            end
            3'd6: begin
                wctl_op  = OP_WSPAWN_EXT;
                use_mask = 3'b110;
            end
            default: begin
                wctl_op  = OP_TMC;
                use_mask = 3'b000;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- decode/op_select.sv
`default_nettype none
`timescale 1ns/10ps

module op_select (
    input  isa_pkg::instr_t instr,
    output uop_pkg::op_t    alu_op,
    output uop_pkg::op_t    br_op,
    output uop_pkg::op_t    sys_op,
    output uop_pkg::op_t    md_op,
    output uop_pkg::op_t    csr_op
);
    import isa_pkg::*;
    import uop_pkg::*;

    funct3_t     funct3;
    funct7_t     funct7;
    logic [11:0] funct12;
    logic        is_reg;

    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20];
    assign is_reg  = (instr[6:0] == OPC_REG);

    always_comb begin
        case (funct3)
            3'd0:    alu_op = (is_reg && funct7[5]) ? OP_SUB : OP_ADD; // ADDI has no SUB form
            3'd1:    alu_op = OP_SLL;
            3'd2:    alu_op = OP_SLT;
            3'd3:    alu_op = OP_SLTU;
            3'd4:    alu_op = OP_XOR;
            3'd5:    alu_op = funct7[5] ? OP_SRA : OP_SRL;
            3'd6:    alu_op = OP_OR;
            default: alu_op = OP_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            3'd1:    br_op = OP_BNE;
            3'd4:    br_op = OP_BLT;
            3'd5:    br_op = OP_BGE;
            3'd6:    br_op = OP_BLTU;
            3'd7:    br_op = OP_BGEU;
            default: br_op = OP_BEQ;
        endcase
    end

    always_comb begin
        case (funct12)
            12'h001: sys_op = OP_EBREAK;
            12'h002: sys_op = OP_URET;
            12'h102: sys_op = OP_SRET;
            12'h302: sys_op = OP_MRET;
            default: sys_op = OP_ECALL;
        endcase
    end

    always_comb begin
        case (funct3)
            3'd0:    md_op = OP_MUL;
            3'd1:    md_op = OP_MULH;
            3'd2:    md_op = OP_MULHSU;
            3'd3:    md_op = OP_MULHU;
            3'd4:    md_op = OP_DIV;
            3'd5:    md_op = OP_DIVU;
            3'd6:    md_op = OP_REM;
            default: md_op = OP_REMU;
        endcase
    end

    // Bit 2 selects the immediate form, handled in the decoder
    always_comb begin
        case (funct3[1:0])
            2'd2:    csr_op = OP_CSRRS;
            2'd3:    csr_op = OP_CSRRC;
            default: csr_op = OP_CSRRW;
        endcase
    end

endmodule

`default_nettype wire

//--- decode/imm_gen.sv
`default_nettype none
`timescale 1ns/10ps

module imm_gen (
    input  isa_pkg::instr_t instr,
    output uop_pkg::xlen_t  i_imm,
    output uop_pkg::xlen_t  s_imm,
    output uop_pkg::xlen_t  b_imm,
    output uop_pkg::xlen_t  u_imm,
    output uop_pkg::xlen_t  j_imm
);
    import isa_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    is_shift;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // SLLI, SRLI, SRAI carry a shift amount, not an immediate
    assign is_shift = (opcode == OPC_IMM) && funct3[0] && !funct3[1];

    assign i_imm = is_shift ? {27'b0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

`default_nettype wire

//--- common/uop_pkg.sv
`default_nettype none

package uop_pkg;

    localparam int XLEN        = 32;
    localparam int WARP_BITS   = 2;
    localparam int NUM_THREADS = 4;
    localparam int UUID_BITS   = 16;

    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [WARP_BITS-1:0]   wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [UUID_BITS-1:0]   uuid_t;

    typedef logic [1:0] ex_t;
    localparam ex_t EX_ALU = 2'd0;
    localparam ex_t EX_LSU = 2'd1;
    localparam ex_t EX_SFU = 2'd2;

    typedef logic [3:0] op_t;
    // ALU
    localparam op_t OP_ADD   = 4'h0;
    localparam op_t OP_SLL   = 4'h1;
    localparam op_t OP_SLT   = 4'h2;
    localparam op_t OP_SLTU  = 4'h3;
    localparam op_t OP_XOR   = 4'h4;
    localparam op_t OP_SRL   = 4'h5;
    localparam op_t OP_OR    = 4'h6;
    localparam op_t OP_AND   = 4'h7;
    localparam op_t OP_SUB   = 4'h8;
    localparam op_t OP_SRA   = 4'h9;
    localparam op_t OP_LUI   = 4'hA;
    localparam op_t OP_AUIPC = 4'hB;
    // Branch unit, xtype BRANCH
    localparam op_t OP_BEQ    = 4'h0;
    localparam op_t OP_BNE    = 4'h1;
    localparam op_t OP_BLT    = 4'h2;
    localparam op_t OP_BGE    = 4'h3;
    localparam op_t OP_BLTU   = 4'h4;
    localparam op_t OP_BGEU   = 4'h5;
    localparam op_t OP_JAL    = 4'h6;
    localparam op_t OP_JALR   = 4'h7;
    localparam op_t OP_ECALL  = 4'h8;
    localparam op_t OP_EBREAK = 4'h9;
    localparam op_t OP_URET   = 4'hA;
    localparam op_t OP_SRET   = 4'hB;
    localparam op_t OP_MRET   = 4'hC;
    // M extension, in funct3 order
    localparam op_t OP_MUL    = 4'h0;
    localparam op_t OP_MULH   = 4'h1;
    localparam op_t OP_MULHSU = 4'h2;
    localparam op_t OP_MULHU  = 4'h3;
    localparam op_t OP_DIV    = 4'h4;
    localparam op_t OP_DIVU   = 4'h5;
    localparam op_t OP_REM    = 4'h6;
    localparam op_t OP_REMU   = 4'h7;
    // LSU op is {store, funct3}
    localparam op_t OP_LD    = 4'h0;
    localparam op_t OP_ST    = 4'h8;
    localparam op_t OP_FENCE = 4'hF;
    // SFU, warp control then CSR
    localparam op_t OP_TMC        = 4'h0;
    localparam op_t OP_WSPAWN     = 4'h1;
    localparam op_t OP_SPLIT      = 4'h2;
    localparam op_t OP_JOIN       = 4'h3;
    localparam op_t OP_BAR        = 4'h4;
    localparam op_t OP_PRED       = 4'h5;
    localparam op_t OP_WSPAWN_EXT = 4'h6;
    localparam op_t OP_CSRRW      = 4'h7;
    localparam op_t OP_CSRRS      = 4'h8;
    localparam op_t OP_CSRRC      = 4'h9;

    typedef logic [1:0] xtype_t;
    localparam xtype_t XT_ARITH  = 2'd0;
    localparam xtype_t XT_BRANCH = 2'd1;
    localparam xtype_t XT_MULDIV = 2'd2;
    localparam xtype_t XT_OTHER  = 2'd3;

    // Payload word, read according to ex_type
    typedef union packed {
        xlen_t word;
        struct packed {
            logic [19:0] rsvd;
            logic [11:0] offset;
        } lsu;
        struct packed {
            logic [14:0]        rsvd;
            isa_pkg::csr_addr_t addr;
            isa_pkg::reg_idx_t  zimm;
        } csr;
    } arg_data_t;

    typedef struct packed {
        xtype_t     xtype;
        logic       use_pc;
        logic       use_imm;
        logic       csr_imm;
        logic       is_neg;
        logic [1:0] rsvd;
        arg_data_t  imm;
    } op_args_t; // 40 bits

    typedef struct packed {
        uuid_t           uuid;
        wid_t            wid;
        tmask_t          tmask;
        xlen_t           pc;
        isa_pkg::instr_t instr;
    } fetch_t;

    typedef struct packed {
        uuid_t             uuid;
        wid_t              wid;
        tmask_t            tmask;
        xlen_t             pc;
        ex_t               ex_type;
        op_t               op_type;
        op_args_t          op_args;
        logic              wb;
        logic [2:0]        used_rs; // {rs3, rs2, rs1}
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::reg_idx_t rs3;
    } uop_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic unlock;
    } sched_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] csr_addr_t;

    // Major opcodes, instr[6:0]
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_IMM    = 7'b0010011;
    localparam opcode_t OPC_REG    = 7'b0110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;
    localparam opcode_t OPC_SYS    = 7'b1110011;
    localparam opcode_t OPC_EXT1   = 7'b0001011; // custom-0, GPU extensions

    localparam funct7_t F7_MULDIV = 7'h01;

    // Within OPC_EXT1
    localparam funct7_t F7_WCTL = 7'h00;
    localparam funct7_t F7_VOTE = 7'h01;

    // fflags, frm, fcsr live at the bottom of the CSR space
    localparam csr_addr_t CSR_FPU_LAST = 12'h003;

endpackage

`default_nettype wire
